//--- common/gpioPkg.sv
/*
 * GPIO package
 * Data type, register bit positions, reset values and shunt timer states
 */
package gpioPkg;

    localparam int dataWidth = 32;
    typedef logic [dataWidth-1:0] dataT;

    // Writable outputs live in the low half of every group
    localparam int outFieldWidth = 16;
    localparam int shuntModeBit = 31;

    ////////////////////////////////////////
    // Power group
    localparam int pwrFanEnBit = 0;
    localparam int pwrIsoEnBit = 1;
    localparam int pwrGoodNBit = 16;
    localparam int pwrFanFailNBit = 17;

    // Gantry 96 V group
    localparam int gntMotPwrEnBit = 0;
    localparam int gntBrkPwrEnBit = 1;
    localparam int gntShuntEnBit = 2;
    localparam int gntMotOcBit = 16;
    localparam int gntBrkOcBit = 17;
    localparam int gntMotFltNBit = 18;
    localparam int gntBrkFltNBit = 19;
    localparam int gntShuntOnBit = 20;

    // Lift 96 V group
    localparam int lftShuntEnBit = 1;
    localparam int lftMotPwrEnBit = 3;
    localparam int lftShuntOnBit = 16;
    localparam int lftMotFltNBit = 17;

    // ADC select and one-cold mux field
    localparam int adSelLsb = 0;
    localparam int adSelWidth = 3;
    localparam int adMuxLsb = 3;
    localparam int adMuxCount = 5;

    ////////////////////////////////////////
    // All muxes off after reset
    localparam dataT adcResetValue = 32'h000000F8;
    // 2.5 s at 100 MHz
    localparam dataT shuntCntMaxDefault = 32'd250_000_000;

    typedef enum logic [1:0] {
        shuntIdle,
        shuntCounting,
        shuntDone
    } shuntStateT;

endpackage

//--- common/gpioRegIf.sv
/*
 * GPIO register interface
 * Register contents plus shunt run and expiry flags shared by bank, timers and output stage
 */
interface gpioRegIf;
    import gpioPkg::*;

    dataT powerReg;
    dataT gantryReg;
    dataT liftReg;
    dataT adcReg;

    // Shunt pulse control
    logic gntShuntRun;
    logic lftShuntRun;
    dataT shuntCntMax;
    logic gntShuntExpired;
    logic lftShuntExpired;

    modport bank (
        output powerReg, gantryReg, liftReg, adcReg,
        output gntShuntRun, lftShuntRun, shuntCntMax,
        input  gntShuntExpired, lftShuntExpired
    );

    modport timer (
        input  gntShuntRun, lftShuntRun, shuntCntMax,
        output gntShuntExpired, lftShuntExpired
    );

    modport outStage (
        input powerReg, gantryReg, liftReg, adcReg
    );

endinterface

//--- rtl/shuntPulseTimer.sv
/*
 * Shunt pulse timer
 * Counts cycles while a pulse-mode shunt enable is set and flags the programmed length
 */
module shuntPulseTimer (
    input  logic          OPB_CLK,
    input  logic          OPB_RST,
    input  logic          run,
    input  gpioPkg::dataT cntMax,
    output logic          expired
);
    import gpioPkg::*;

    shuntStateT state;
    dataT       cnt;

    always_ff @(posedge OPB_CLK or posedge OPB_RST) begin
        if (OPB_RST) begin
            state <= shuntIdle;
            cnt   <= '0;
        end else if (!run) begin
            state <= shuntIdle;
            cnt   <= '0;
        end else begin
            unique case (state)
                shuntIdle, shuntCounting: begin
                    // Clamp also covers a length lowered mid-pulse
                    if (cnt >= cntMax) begin
                        cnt   <= cntMax;
                        state <= shuntDone;
                    end else begin
                        cnt   <= cnt + 1'b1;
                        state <= shuntCounting;
                    end
                end
                shuntDone: begin
                    // Hold at the limit until the bank drops run
                    cnt <= cntMax;
                end
                default: begin
                    state <= shuntIdle;
                    cnt   <= '0;
                end
            endcase
        end
    end

    assign expired = run && (cnt == cntMax);

    // Count may only overshoot in the cycle right after the length changes
    cntWithinMax: assert property (@(posedge OPB_CLK) disable iff (OPB_RST)
        $stable(cntMax) |-> (cnt <= cntMax))
        else $error("shuntPulseTimer: count above programmed length");

endmodule

//--- rtl/gpioOutputStage.sv
/*
 * GPIO output stage
 * Registered OPB read mux, register to pin mapping and ADC mux enable decode
 */
module gpioOutputStage (
    input  logic                            OPB_CLK,
    input  logic                            OPB_RST,
    input  logic                            pwrIfRe,
    input  logic                            gantry96vIfRe,
    input  logic                            lift96vIfRe,
    input  logic                            adcSelMuxIfRe,
    gpioRegIf.outStage                      regs,
    output gpioPkg::dataT                   opbDo,
    output logic                            fanEn,
    output logic                            p12vIsoEn,
    output logic                            gntMotPwrEn,
    output logic                            gntBrkPwrEn,
    output logic                            gntShuntEn,
    output logic                            lftShuntEn,
    output logic                            lftMotPwrEn,
    output logic [gpioPkg::adSelWidth-1:0]  adSel,
    output logic [gpioPkg::adMuxCount-1:0]  adMuxN
);
    import gpioPkg::*;

    logic [adMuxCount-1:0] muxField;

    ////////////////////////////////////////
    // OPB read, one cycle latency
    always_ff @(posedge OPB_CLK or posedge OPB_RST) begin
        if (OPB_RST) begin
            opbDo <= '0;
        end else if (pwrIfRe) begin
            opbDo <= regs.powerReg;
        end else if (gantry96vIfRe) begin
            opbDo <= regs.gantryReg;
        end else if (lift96vIfRe) begin
            opbDo <= regs.liftReg;
        end else if (adcSelMuxIfRe) begin
            opbDo <= regs.adcReg;
        end else begin
            opbDo <= '0;
        end
    end

    ////////////////////////////////////////
    // Pin mapping
    assign fanEn       = regs.powerReg[pwrFanEnBit];
    assign p12vIsoEn   = regs.powerReg[pwrIsoEnBit];

    assign gntMotPwrEn = regs.gantryReg[gntMotPwrEnBit];
    assign gntBrkPwrEn = regs.gantryReg[gntBrkPwrEnBit];
    assign gntShuntEn  = regs.gantryReg[gntShuntEnBit];

    assign lftShuntEn  = regs.liftReg[lftShuntEnBit];
    assign lftMotPwrEn = regs.liftReg[lftMotPwrEnBit];

    assign adSel    = regs.adcReg[adSelLsb +: adSelWidth];
    assign muxField = regs.adcReg[adMuxLsb +: adMuxCount];

    // Mux i is enabled (low) only when field bit i is the single zero
    always_comb begin
        for (int i = 0; i < adMuxCount; i++) begin
            adMuxN[i] = (muxField != ~(adMuxCount'(1) << i));
        end
    end

endmodule

//--- regbank/opbRegisterBank.sv
/*
 * OPB register bank
 * Write decode, status sampling and shunt auto-clear for the GPIO groups,
 * plus the shunt pulse length register
 */
module opbRegisterBank (
    input  logic          OPB_CLK,
    input  logic          OPB_RST,
    input  gpioPkg::dataT opbDi,
    input  logic          pwrIfWe,
    input  logic          gantry96vIfWe,
    input  logic          lift96vIfWe,
    input  logic          adcSelMuxIfWe,
    input  logic          shuntEnCntWe,
    input  logic          p24vGoodN,
    input  logic          fanFailN,
    input  logic          ocVGntMotDrv,
    input  logic          ocVGntBrkDrv,
    input  logic          gntMotPwrFltN,
    input  logic          gntBrkPwrFltN,
    input  logic          gntShuntOn,
    input  logic          lftShuntOn,
    input  logic          lftMotPwrFltN,
    gpioRegIf.bank        regs
);
    import gpioPkg::*;

    dataT powerReg;
    dataT gantryReg;
    dataT liftReg;
    dataT adcReg;
    dataT shuntCntMax;

    ////////////////////////////////////////
    // Power group
    always_ff @(posedge OPB_CLK or posedge OPB_RST) begin
        if (OPB_RST) begin
            powerReg <= '0;
        end else if (pwrIfWe) begin
            powerReg[outFieldWidth-1:0] <= opbDi[outFieldWidth-1:0];
        end else begin
            powerReg[pwrGoodNBit]    <= p24vGoodN;
            powerReg[pwrFanFailNBit] <= fanFailN;
        end
    end

    ////////////////////////////////////////
    // Gantry 96 V group
    always_ff @(posedge OPB_CLK or posedge OPB_RST) begin
        if (OPB_RST) begin
            gantryReg <= '0;
        end else if (gantry96vIfWe) begin
            gantryReg[outFieldWidth-1:0] <= opbDi[outFieldWidth-1:0];
            gantryReg[shuntModeBit]      <= opbDi[shuntModeBit];
        end else begin
            gantryReg[gntMotOcBit]   <= ocVGntMotDrv;
            gantryReg[gntBrkOcBit]   <= ocVGntBrkDrv;
            gantryReg[gntMotFltNBit] <= gntMotPwrFltN;
            gantryReg[gntBrkFltNBit] <= gntBrkPwrFltN;
            gantryReg[gntShuntOnBit] <= gntShuntOn;
            // End of shunt pulse
            if (regs.gntShuntExpired) begin
                gantryReg[gntShuntEnBit] <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // Lift 96 V group
    always_ff @(posedge OPB_CLK or posedge OPB_RST) begin
        if (OPB_RST) begin
            liftReg <= '0;
        end else if (lift96vIfWe) begin
            liftReg[outFieldWidth-1:0] <= opbDi[outFieldWidth-1:0];
            liftReg[shuntModeBit]      <= opbDi[shuntModeBit];
        end else begin
            liftReg[lftShuntOnBit] <= lftShuntOn;
            liftReg[lftMotFltNBit] <= lftMotPwrFltN;
            if (regs.lftShuntExpired) begin
                liftReg[lftShuntEnBit] <= 1'b0;
            end
        end
    end

    // ADC select and mux, no status inputs
    always_ff @(posedge OPB_CLK or posedge OPB_RST) begin
        if (OPB_RST) begin
            adcReg <= adcResetValue;
        end else if (adcSelMuxIfWe) begin
            adcReg[outFieldWidth-1:0] <= opbDi[outFieldWidth-1:0];
        end
    end

    // Shunt pulse length in clock cycles
    always_ff @(posedge OPB_CLK or posedge OPB_RST) begin
        if (OPB_RST) begin
            shuntCntMax <= shuntCntMaxDefault;
        end else if (shuntEnCntWe) begin
            shuntCntMax <= opbDi;
        end
    end

    // Run drops for one cycle on any write to the group,
    // so a rewrite during a pulse restarts the count
    assign regs.gntShuntRun = gantryReg[gntShuntEnBit] && gantryReg[shuntModeBit]
                              && !gantry96vIfWe;
    assign regs.lftShuntRun = liftReg[lftShuntEnBit] && liftReg[shuntModeBit]
                              && !lift96vIfWe;

    assign regs.powerReg    = powerReg;
    assign regs.gantryReg   = gantryReg;
    assign regs.liftReg     = liftReg;
    assign regs.adcReg      = adcReg;
    assign regs.shuntCntMax = shuntCntMax;

    // Bus master issues one write per cycle
    writeStrobeOneHot: assert property (@(posedge OPB_CLK) disable iff (OPB_RST)
        $onehot0({pwrIfWe, gantry96vIfWe, lift96vIfWe, adcSelMuxIfWe, shuntEnCntWe}))
        else $error("opbRegisterBank: more than one write strobe active");

endmodule

//--- rtl/gpioTop.sv
/*
 * GPIO top level
 * OPB register access to the power, gantry, lift and ADC mux pins
 * with pulse-mode shunt enables
 */
module gpioTop (
    input  logic                            OPB_CLK,
    input  logic                            OPB_RST,
    input  gpioPkg::dataT                   opbDi,
    output gpioPkg::dataT                   opbDo,

    // Read strobes
    input  logic                            pwrIfRe,
    input  logic                            gantry96vIfRe,
    input  logic                            lift96vIfRe,
    input  logic                            adcSelMuxIfRe,

    // Write strobes
    input  logic                            pwrIfWe,
    input  logic                            gantry96vIfWe,
    input  logic                            lift96vIfWe,
    input  logic                            adcSelMuxIfWe,
    input  logic                            shuntEnCntWe,

    // Status pins
    input  logic                            p24vGoodN,
    input  logic                            fanFailN,
    input  logic                            ocVGntMotDrv,
    input  logic                            ocVGntBrkDrv,
    input  logic                            gntMotPwrFltN,
    input  logic                            gntBrkPwrFltN,
    input  logic                            gntShuntOn,
    input  logic                            lftShuntOn,
    input  logic                            lftMotPwrFltN,

    // Enable pins
    output logic                            fanEn,
    output logic                            p12vIsoEn,
    output logic                            gntMotPwrEn,
    output logic                            gntBrkPwrEn,
    output logic                            gntShuntEn,
    output logic                            lftShuntEn,
    output logic                            lftMotPwrEn,
    output logic [gpioPkg::adSelWidth-1:0]  adSel,
    output logic [gpioPkg::adMuxCount-1:0]  adMuxN
);

    gpioRegIf regIf ();

    opbRegisterBank regBank0 (
        .OPB_CLK       (OPB_CLK),
        .OPB_RST       (OPB_RST),
        .opbDi         (opbDi),
        .pwrIfWe       (pwrIfWe),
        .gantry96vIfWe (gantry96vIfWe),
        .lift96vIfWe   (lift96vIfWe),
        .adcSelMuxIfWe (adcSelMuxIfWe),
        .shuntEnCntWe  (shuntEnCntWe),
        .p24vGoodN     (p24vGoodN),
        .fanFailN      (fanFailN),
        .ocVGntMotDrv  (ocVGntMotDrv),
        .ocVGntBrkDrv  (ocVGntBrkDrv),
        .gntMotPwrFltN (gntMotPwrFltN),
        .gntBrkPwrFltN (gntBrkPwrFltN),
        .gntShuntOn    (gntShuntOn),
        .lftShuntOn    (lftShuntOn),
        .lftMotPwrFltN (lftMotPwrFltN),
        .regs          (regIf.bank)
    );

    // One timer per shunt enable
    shuntPulseTimer gntTimer0 (
        .OPB_CLK (OPB_CLK),
        .OPB_RST (OPB_RST),
        .run     (regIf.gntShuntRun),
        .cntMax  (regIf.shuntCntMax),
        .expired (regIf.gntShuntExpired)
    );

    shuntPulseTimer lftTimer0 (
        .OPB_CLK (OPB_CLK),
        .OPB_RST (OPB_RST),
        .run     (regIf.lftShuntRun),
        .cntMax  (regIf.shuntCntMax),
        .expired (regIf.lftShuntExpired)
    );

    gpioOutputStage outStage0 (
        .OPB_CLK       (OPB_CLK),
        .OPB_RST       (OPB_RST),
        .pwrIfRe       (pwrIfRe),
        .gantry96vIfRe (gantry96vIfRe),
        .lift96vIfRe   (lift96vIfRe),
        .adcSelMuxIfRe (adcSelMuxIfRe),
        .regs          (regIf.outStage),
        .opbDo         (opbDo),
        .fanEn         (fanEn),
        .p12vIsoEn     (p12vIsoEn),
        .gntMotPwrEn   (gntMotPwrEn),
        .gntBrkPwrEn   (gntBrkPwrEn),
        .gntShuntEn    (gntShuntEn),
        .lftShuntEn    (lftShuntEn),
        .lftMotPwrEn   (lftMotPwrEn),
        .adSel         (adSel),
        .adMuxN        (adMuxN)
    );

endmodule

//--- sim/gpioTbRef.svh
/*
 * GPIO testbench reference model
 * Expected OPB readback words and expected pin levels
 */
`ifndef GPIO_TB_REF_SVH
`define GPIO_TB_REF_SVH

// Status order: 0 p24vGoodN, 1 fanFailN, 2..6 gantry, 7 lftShuntOn, 8 lftMotPwrFltN
function automatic logic [31:0] refReadWord(input int grp, input logic [31:0] written,
                                            input logic [8:0] status);
    logic [31:0] word;
    word = '0;
    word[15:0] = written[15:0];
    case (grp)
        0: begin
            word[16] = status[0];
            word[17] = status[1];
        end
        1: begin
            word[20:16] = status[6:2];
            word[31]    = written[31];
        end
        2: begin
            word[16] = status[7];
            word[17] = status[8];
            word[31] = written[31];
        end
        default: begin
        end
    endcase
    return word;
endfunction

// Pin order: fan, iso, gantry mot/brk/shunt, lift shunt/mot, adSel, adMuxN
function automatic logic [14:0] refPins(input logic [31:0] power, input logic [31:0] gantry,
                                        input logic [31:0] lift, input logic [31:0] adc);
    logic [14:0] pins;
    pins[0]   = power[0];
    pins[1]   = power[1];
    pins[2]   = gantry[0];
    pins[3]   = gantry[1];
    pins[4]   = gantry[2];
    pins[5]   = lift[1];
    pins[6]   = lift[3];
    pins[9:7] = adc[2:0];
    for (int i = 0; i < 5; i++) begin
        // Low only for the single zero at position i
        pins[10 + i] = (adc[7:3] == (5'b11111 ^ (5'b00001 << i))) ? 1'b0 : 1'b1;
    end
    return pins;
endfunction

`endif

//--- sim/gpioTb.sv
/*
 * GPIO testbench
 * Drives OPB writes and reads, status pins and shunt pulses into gpioTop
 */
module gpioTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int pulseTimeout = 200;
    localparam int drainTimeout = 20;

    logic        OPB_CLK;
    logic        OPB_RST;
    logic [31:0] opbDi;
    logic [31:0] opbDo;
    logic        pwrIfRe, gantry96vIfRe, lift96vIfRe, adcSelMuxIfRe;
    logic        pwrIfWe, gantry96vIfWe, lift96vIfWe, adcSelMuxIfWe, shuntEnCntWe;
    logic [8:0]  statusPins;
    logic        fanEn, p12vIsoEn, gntMotPwrEn, gntBrkPwrEn, gntShuntEn;
    logic        lftShuntEn, lftMotPwrEn;
    logic [2:0]  adSel;
    logic [4:0]  adMuxN;

    // Model of the written fields
    logic [31:0] mPower, mGantry, mLift, mAdc;
    int          mCntMax;

    logic [31:0] expWordQ[$];
    logic [14:0] expPinQ[$];

    `include "gpioTbRef.svh"

    gpioTop dut0 (
        .OPB_CLK(OPB_CLK), .OPB_RST(OPB_RST), .opbDi(opbDi), .opbDo(opbDo),
        .pwrIfRe(pwrIfRe), .gantry96vIfRe(gantry96vIfRe), .lift96vIfRe(lift96vIfRe),
        .adcSelMuxIfRe(adcSelMuxIfRe),
        .pwrIfWe(pwrIfWe), .gantry96vIfWe(gantry96vIfWe), .lift96vIfWe(lift96vIfWe),
        .adcSelMuxIfWe(adcSelMuxIfWe), .shuntEnCntWe(shuntEnCntWe),
        .p24vGoodN(statusPins[0]), .fanFailN(statusPins[1]),
        .ocVGntMotDrv(statusPins[2]), .ocVGntBrkDrv(statusPins[3]),
        .gntMotPwrFltN(statusPins[4]), .gntBrkPwrFltN(statusPins[5]),
        .gntShuntOn(statusPins[6]), .lftShuntOn(statusPins[7]),
        .lftMotPwrFltN(statusPins[8]),
        .fanEn(fanEn), .p12vIsoEn(p12vIsoEn), .gntMotPwrEn(gntMotPwrEn),
        .gntBrkPwrEn(gntBrkPwrEn), .gntShuntEn(gntShuntEn), .lftShuntEn(lftShuntEn),
        .lftMotPwrEn(lftMotPwrEn), .adSel(adSel), .adMuxN(adMuxN)
    );

    initial OPB_CLK = 1'b0;
    always #2 OPB_CLK = ~OPB_CLK;

    function automatic logic [14:0] pinVector();
        return {adMuxN, adSel, lftMotPwrEn, lftShuntEn, gntShuntEn, gntBrkPwrEn,
                gntMotPwrEn, p12vIsoEn, fanEn};
    endfunction

    task automatic reportFailure(input string line);
        $display("%s", line);
        $display("TESTBENCH FAILED");
    endtask

    // Groups 0 to 3 are registers and 4 is the pulse length
    task automatic writeReg(input int grp, input logic [31:0] data);
        @(negedge OPB_CLK);
        opbDi = data;
        case (grp)
            0: begin
                pwrIfWe = 1'b1;
                mPower[15:0] = data[15:0];
            end
            1: begin
                gantry96vIfWe = 1'b1;
                mGantry = {data[31], 15'b0, data[15:0]};
            end
            2: begin
                lift96vIfWe = 1'b1;
                mLift = {data[31], 15'b0, data[15:0]};
            end
            3: begin
                adcSelMuxIfWe = 1'b1;
                mAdc[15:0] = data[15:0];
            end
            default: begin
                shuntEnCntWe = 1'b1;
                mCntMax = int'(data);
            end
        endcase
        if (grp < 4)
            expPinQ.push_back(refPins(mPower, mGantry, mLift, mAdc));
        @(negedge OPB_CLK);
        {pwrIfWe, gantry96vIfWe, lift96vIfWe, adcSelMuxIfWe, shuntEnCntWe} = '0;
        opbDi = $urandom;
    endtask

    // Mask bits select power, gantry, lift and ADC from bit 0 up
    task automatic readMask(input logic [3:0] mask);
        logic [31:0] expWord;
        @(negedge OPB_CLK);
        {adcSelMuxIfRe, lift96vIfRe, gantry96vIfRe, pwrIfRe} = mask;
        if (mask[0])
            expWord = refReadWord(0, mPower, statusPins);
        else if (mask[1])
            expWord = refReadWord(1, mGantry, statusPins);
        else if (mask[2])
            expWord = refReadWord(2, mLift, statusPins);
        else if (mask[3])
            expWord = refReadWord(3, mAdc, statusPins);
        else
            expWord = '0;
        expWordQ.push_back(expWord);
        @(negedge OPB_CLK);
        {adcSelMuxIfRe, lift96vIfRe, gantry96vIfRe, pwrIfRe} = '0;
    endtask

    // Counts negedges with the shunt enable high from the current one on
    task automatic measurePulse(input bit liftSide, output int highCycles);
        int guard;
        highCycles = 0;
        guard = 0;
        while ((liftSide ? lftShuntEn : gntShuntEn) === 1'b1 && guard < pulseTimeout) begin
            highCycles++;
            guard++;
            @(negedge OPB_CLK);
        end
        assert (guard < pulseTimeout) else begin
            reportFailure("Shunt enable did not clear within the timeout");
            $fatal(1, "pulse timeout");
        end
    endtask

    ////////////////////////////////////////
    // Comparison process samples 1 ns after each rising edge
    initial begin
        logic [31:0] expWord;
        logic [14:0] expPins;
        forever begin
            @(posedge OPB_CLK);
            #1;
            while (expWordQ.size() > 0) begin
                expWord = expWordQ.pop_front();
                assert (opbDo === expWord) else begin
                    reportFailure($sformatf("FAILED at %0t: opbDo %h, expected %h",
                                            $time, opbDo, expWord));
                    $fatal(1, "read mismatch");
                end
            end
            while (expPinQ.size() > 0) begin
                expPins = expPinQ.pop_front();
                assert (pinVector() === expPins) else begin
                    reportFailure($sformatf("FAILED at %0t: pins %b, expected %b",
                                            $time, pinVector(), expPins));
                    $fatal(1, "pin mismatch");
                end
            end
        end
    end

    ////////////////////////////////////////
    // Stimulus
    initial begin
        logic [31:0] data;
        int          cycles;
        int          gap;
        int          guard;
        void'($urandom(32'hacc162b4));
        OPB_RST = 1'b1;
        opbDi = '0;
        statusPins = '0;
        {pwrIfRe, gantry96vIfRe, lift96vIfRe, adcSelMuxIfRe} = '0;
        {pwrIfWe, gantry96vIfWe, lift96vIfWe, adcSelMuxIfWe, shuntEnCntWe} = '0;
        mPower = '0;
        mGantry = '0;
        mLift = '0;
        mAdc = 32'h0000_00F8;
        mCntMax = 250_000_000;
        repeat (3) @(negedge OPB_CLK);
        OPB_RST = 1'b0;

        // Reset values
        expPinQ.push_back(refPins(mPower, mGantry, mLift, mAdc));
        for (int g = 0; g < 4; g++)
            readMask(4'(1 << g));

        // Random writes with mode 0 and readback
        repeat (8) begin
            @(negedge OPB_CLK);
            statusPins = 9'($urandom);
            repeat (2) @(negedge OPB_CLK);
            writeReg(0, $urandom);
            writeReg(1, $urandom & 32'h7FFF_FFFF);
            writeReg(2, $urandom & 32'h7FFF_FFFF);
            for (int g = 0; g < 3; g++)
                readMask(4'(1 << g));
        end

        // ADC one-cold decode over all 32 field values
        for (int v = 0; v < 32; v++) begin
            data = $urandom;
            data[7:3] = 5'(v);
            writeReg(3, data);
            readMask(4'b1000);
        end

        // Gantry pulse and then a held mode 0 enable
        writeReg(4, 32'(5 + $urandom % 36));
        data = ($urandom & 32'h0000_FFFF) | 32'h8000_0004;
        writeReg(1, data);
        measurePulse(1'b0, cycles);
        assert (cycles == mCntMax + 1) else begin
            reportFailure($sformatf("FAILED at %0t: gantry pulse %0d cycles, expected %0d",
                                    $time, cycles, mCntMax + 1));
            $fatal(1, "gantry pulse length");
        end
        mGantry[2] = 1'b0;
        readMask(4'b0010);
        writeReg(1, 32'h0000_0004);
        repeat (mCntMax + 5) begin
            @(negedge OPB_CLK);
            assert (gntShuntEn === 1'b1) else begin
                reportFailure($sformatf("FAILED at %0t: gantry shunt cleared in mode 0", $time));
                $fatal(1, "gantry mode 0");
            end
        end

        // Lift pulse with a rewrite in the middle
        writeReg(4, 32'(5 + $urandom % 36));
        writeReg(2, 32'h8000_0002);
        gap = 1 + int'($urandom % (mCntMax - 3));
        repeat (gap) begin
            @(negedge OPB_CLK);
            assert (lftShuntEn === 1'b1) else begin
                reportFailure($sformatf("FAILED at %0t: lift shunt cleared early", $time));
                $fatal(1, "lift early clear");
            end
        end
        writeReg(2, 32'h8000_000A);
        measurePulse(1'b1, cycles);
        assert (cycles == mCntMax + 1) else begin
            reportFailure($sformatf("FAILED at %0t: lift pulse %0d cycles, expected %0d",
                                    $time, cycles, mCntMax + 1));
            $fatal(1, "lift pulse length");
        end
        mLift[1] = 1'b0;
        readMask(4'b0100);

        // Read priority and the idle bus
        for (int a = 0; a < 3; a++)
            for (int b = a + 1; b < 4; b++)
                readMask(4'((1 << a) | (1 << b)));
        readMask(4'b1111);
        readMask(4'b0000);

        guard = 0;
        while ((expWordQ.size() > 0 || expPinQ.size() > 0) && guard < drainTimeout) begin
            guard++;
            @(negedge OPB_CLK);
        end
        if (guard < drainTimeout) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            reportFailure("Pending checks were not completed before the end of the run");
            $fatal(1, "run ended with pending checks");
        end
    end

endmodule

//--- project.f
+incdir+sim
common/gpioPkg.sv
common/gpioRegIf.sv
rtl/shuntPulseTimer.sv
rtl/gpioOutputStage.sv
regbank/opbRegisterBank.sv
rtl/gpioTop.sv
sim/gpioTb.sv

//--- Makefile
# Verilator build, run and lint for the GPIO project

VERILATOR  ?= verilator
TOP        ?= gpioTb
FILELIST   ?= project.f
BUILD_DIR  ?= obj_dir
JOBS       ?= 0
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing

SOURCES := $(shell grep -v '^+' $(FILELIST)) sim/gpioTbRef.svh
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Exit status of the simulation is the pass or fail result
run: build
	./$(SIM_BIN)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
